// ==== files.f ====
hw/frv_pkg.sv
hw/frv_fetch_buffer.sv
hw/frv_pipeline_fetch.sv
hw/frv_imem.sv
hw/frv_fetch_top.sv
test/tb_frv_fetch.sv

// ==== hw/frv_fetch_buffer.sv ====
// Fetch buffer
// Halfword queue between the memory response and decode. Works out whether
// the head is a 16-bit or 32-bit instruction and hands one out at a time
`timescale 1ns/1ns
module frv_fetch_buffer (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     flush,     // Drop everything held
    input  logic                     f_4byte,   // Append both halves of f_in
    input  logic                     f_2byte,   // Append upper half of f_in only
    input  logic                     f_err,     // Error flag for the incoming word
    input  frv_pkg::frv_fetch_word_t f_in,      // Memory response word
    output logic                     f_ready,   // Room for all reads in flight
    output logic [frv_pkg::XL:0]     buf_out,   // Instruction at the head
    output logic                     buf_err,   // Error on any halfword used
    output logic                     buf_valid, // Head instruction complete
    input  logic                     buf_ready  // Decode takes the head
);
    import frv_pkg::*;

    logic [BUF_HALVES-1:0][15:0] slot_data;     // Halfword storage, slot 0 is head
    logic [BUF_HALVES-1:0]       slot_vld;      // Contiguous from slot 0
    logic [BUF_HALVES-1:0]       slot_err;

    logic [BUF_HALVES-1:0][15:0] n_data;
    logic [BUF_HALVES-1:0]       n_vld;
    logic [BUF_HALVES-1:0]       n_err;

    logic [BUF_FILL_W-1:0]       fill;          // Valid halfwords held
    logic                        ins_32;        // Head is a full-width instruction
    logic                        consume;
    logic [1:0]                  shift;         // Halfwords freed this cycle
    int                          wr_base;       // First free slot after the shift

    // ------------------------------
    // Head decode
    assign ins_32 = (slot_data[0][1:0] == 2'b11);  // RVC rule on the low bits

    assign buf_valid = ins_32 ? slot_vld[1] : slot_vld[0];
    assign buf_out   = ins_32 ? {slot_data[1], slot_data[0]}
                              : {16'h0000, slot_data[0]};   // Zero-extend RVC
    assign buf_err   = ins_32 ? (slot_err[1] | slot_err[0]) : slot_err[0];

    assign consume = buf_valid && buf_ready;
    assign shift   = consume ? (ins_32 ? 2'd2 : 2'd1) : 2'd0;

    // ------------------------------
    // Occupancy
    always_comb begin
        fill = '0;
        for (int i = 0; i < BUF_HALVES; i++) begin
            if (slot_vld[i]) begin
                fill = fill + 1'b1;
            end
        end
    end

    assign wr_base = int'(fill) - int'(shift);   // Writes land behind the survivors

    // Keep enough space for every read the fetch stage may have in flight
    assign f_ready = (int'(fill) <= BUF_HALVES - 2 * MAX_OUTSTANDING);

    // ------------------------------
    // Shift out consumed halves, append new ones
    always_comb begin
        n_data = slot_data;
        n_vld  = '0;
        n_err  = '0;
        for (int i = 0; i < BUF_HALVES; i++) begin
            if (i + int'(shift) < BUF_HALVES) begin  // Move survivors down
                n_data[i] = slot_data[i + int'(shift)];
                n_vld[i]  = slot_vld[i + int'(shift)];
                n_err[i]  = slot_err[i + int'(shift)];
            end
            if (f_4byte && i == wr_base) begin       // Low half of a full word
                n_data[i] = f_in.half[0];
                n_vld[i]  = 1'b1;
                n_err[i]  = f_err;
            end
            if (f_4byte && i == wr_base + 1) begin   // High half of a full word
                n_data[i] = f_in.half[1];
                n_vld[i]  = 1'b1;
                n_err[i]  = f_err;
            end
            if (f_2byte && i == wr_base) begin       // Misaligned first word
                n_data[i] = f_in.half[1];
                n_vld[i]  = 1'b1;
                n_err[i]  = f_err;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            slot_vld <= '0;                          // Flush wins over a write
            slot_err <= '0;
        end else begin
            slot_vld <= n_vld;
            slot_err <= n_err;
        end
    end

    always_ff @(posedge g_clk) begin
        slot_data <= n_data;                         // Qualified by slot_vld
    end

    // ------------------------------
    // Checks on the fetch stage driving this buffer
    // f_ready must have held back requests early enough for this write to fit
    no_overflow: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (f_4byte || f_2byte) && !flush |-> (wr_base + (f_4byte ? 2 : 1) <= BUF_HALVES));

    one_write_kind: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(f_4byte && f_2byte));

endmodule

// ==== hw/frv_fetch_top.sv ====
// Fetch front end top level
// Fetch stage with its buffer on the request/grant/receive bus of the
// instruction ROM
`timescale 1ns/1ns
module frv_fetch_top (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 cf_req,     // Control flow change request
    input  logic [frv_pkg::XL:0] cf_target,  // Change target address
    output logic                 cf_ack,     // Change taken
    input  logic                 fe_flush,   // Drop buffered instructions
    input  logic                 fe_stall,   // Decode not taking
    output logic                 fe_ready,   // Instruction available
    output logic [frv_pkg::XL:0] d_data,     // Instruction to decode
    output logic                 d_error     // Fetch error on it
);
    import frv_pkg::*;

    // ------------------------------
    // Instruction memory bus
    logic            imem_req;
    logic [XL:0]     imem_addr;
    logic            imem_gnt;
    logic            imem_recv;
    logic            imem_error;
    frv_fetch_word_t imem_rdata;

    frv_pipeline_fetch u_fetch (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .cf_req     (cf_req),
        .cf_target  (cf_target),
        .cf_ack     (cf_ack),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_gnt   (imem_gnt),
        .imem_recv  (imem_recv),
        .imem_error (imem_error),
        .imem_rdata (imem_rdata),
        .fe_flush   (fe_flush),
        .fe_stall   (fe_stall),
        .fe_ready   (fe_ready),
        .d_data     (d_data),
        .d_error    (d_error)
    );

    frv_imem u_imem (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_gnt   (imem_gnt),
        .imem_recv  (imem_recv),
        .imem_error (imem_error),
        .imem_rdata (imem_rdata)
    );

endmodule

// ==== hw/frv_imem.sv ====
// Instruction ROM
// Word array loaded from a hex image. Grants every request at once and
// answers one cycle later, with an error outside the ROM window
`timescale 1ns/1ns
module frv_imem (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     imem_req,   // Read request
    input  logic [frv_pkg::XL:0]     imem_addr,  // Byte address
    output logic                     imem_gnt,   // Always accepts
    output logic                     imem_recv,  // Response one cycle later
    output logic                     imem_error, // Address outside the window
    output frv_pkg::frv_fetch_word_t imem_rdata  // Read word
);
    import frv_pkg::*;

    logic [XL:0]        rom [IMEM_WORDS];        // Instruction image
    logic [XL:0]        offset;                  // Distance from window base
    logic               in_window;
    logic [IMEM_AW-1:0] word_idx;
    logic               accept;

    initial begin
        $readmemh(IMEM_FILE, rom);
    end

    // ------------------------------
    // Request side
    assign imem_gnt = imem_req;                  // No wait states
    assign accept   = imem_req && imem_gnt;

    assign offset    = imem_addr - PC_RESET_VALUE;
    assign in_window = (offset[XL:IMEM_AW+2] == '0);   // Below base wraps high
    assign word_idx  = offset[IMEM_AW+1:2];

    // ------------------------------
    // Response side
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_recv <= 1'b0;
        end else begin
            imem_recv <= accept;                 // One pulse per accepted read
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            imem_error      <= !in_window;
            imem_rdata.word <= in_window ? rom[word_idx] : '0;   // Zero on error
        end
    end

endmodule

// ==== hw/frv_pipeline_fetch.sv ====
// Fetch pipeline stage
// Issues word-aligned reads to instruction memory, counts reads in flight,
// takes control flow changes and feeds returned words to the fetch buffer
`timescale 1ns/1ns
module frv_pipeline_fetch (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     cf_req,     // Control flow change request
    input  logic [frv_pkg::XL:0]     cf_target,  // Change target address
    output logic                     cf_ack,     // Change taken this cycle
    output logic                     imem_req,   // Read request
    output logic [frv_pkg::XL:0]     imem_addr,  // Word-aligned read address
    input  logic                     imem_gnt,   // Request accepted
    input  logic                     imem_recv,  // Response strobe
    input  logic                     imem_error, // Response error
    input  frv_pkg::frv_fetch_word_t imem_rdata, // Response data
    input  logic                     fe_flush,   // Drop buffered instructions
    input  logic                     fe_stall,   // Hold the current instruction
    output logic                     fe_ready,   // Instruction available
    output logic [frv_pkg::XL:0]     d_data,     // Instruction to decode
    output logic                     d_error     // Fetch error on it
);
    import frv_pkg::*;

    logic                 f_ready;
    logic                 f_4byte;
    logic                 f_2byte;
    logic                 buf_valid;
    logic                 buf_ready;

    logic [OUT_CNT_W-1:0] reqs_outstanding;
    logic [OUT_CNT_W-1:0] n_reqs_outstanding;
    logic                 cf_change;
    logic                 progress_imem_addr;
    logic                 n_imem_req;

    logic                 misalign_q;            // Next live response is misaligned
    logic                 stale_q;               // Next response predates the change
    logic                 resp_live;

    // ------------------------------
    // Pipeline progression
    assign fe_ready  = buf_valid;
    assign buf_ready = fe_ready && !fe_stall;    // Consume 2 or 4 bytes

    // Only change course with the bus quiet
    assign cf_ack    = (!imem_req || imem_gnt) && (reqs_outstanding == '0);
    assign cf_change = cf_req && cf_ack;

    // ------------------------------
    // Memory bus requests
    assign progress_imem_addr = imem_req && imem_gnt;

    assign n_reqs_outstanding = reqs_outstanding
                              + OUT_CNT_W'(progress_imem_addr)
                              - OUT_CNT_W'(imem_recv);

    // Stop new reads while a change waits, so the bus drains for cf_ack
    assign n_imem_req = cf_change
                     || (f_ready && !cf_req && (n_reqs_outstanding < MAX_OUTSTANDING));

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_addr <= PC_RESET_VALUE;
        end else if (cf_change) begin
            imem_addr <= {cf_target[XL:2], 2'b00};   // Word holding the target
        end else if (progress_imem_addr) begin
            imem_addr <= imem_addr + 32'd4;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req         <= 1'b0;
            reqs_outstanding <= '0;
        end else begin
            imem_req         <= n_imem_req;
            reqs_outstanding <= n_reqs_outstanding;
        end
    end

    // ------------------------------
    // Misalignment and stale response tracking
    // A read granted in the change cycle still targets the old stream
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            misalign_q <= 1'b0;
            stale_q    <= 1'b0;
        end else if (cf_change) begin
            misalign_q <= cf_target[1];              // Target in upper halfword
            stale_q    <= progress_imem_addr;
        end else if (imem_recv) begin
            stale_q <= 1'b0;
            if (!stale_q) begin
                misalign_q <= 1'b0;                  // First live word consumed it
            end
        end
    end

    // ------------------------------
    // Memory bus responses
    assign resp_live = imem_recv && !stale_q;
    assign f_4byte   = resp_live && !misalign_q;
    assign f_2byte   = resp_live &&  misalign_q;

    frv_fetch_buffer u_fetch_buffer (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (fe_flush),
        .f_4byte   (f_4byte),
        .f_2byte   (f_2byte),
        .f_err     (imem_error),
        .f_in      (imem_rdata),
        .f_ready   (f_ready),
        .buf_out   (d_data),
        .buf_err   (d_error),
        .buf_valid (buf_valid),
        .buf_ready (buf_ready)
    );

    // ------------------------------
    // Bus protocol checks against the memory side
    recv_has_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        imem_recv |-> (reqs_outstanding != '0));

    // A new read with nothing returning must leave room under the limit
    out_limit: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (progress_imem_addr && !imem_recv) |-> (reqs_outstanding < MAX_OUTSTANDING));

endmodule

// ==== hw/frv_pkg.sv ====
// Fetch front end shared definitions
// Core widths, reset PC, ROM geometry, buffer sizing and the fetch word type
package frv_pkg;

    // ------------------------------
    // Core widths
    localparam int XL = 31;                             // Top bit of data/address word

    localparam logic [XL:0] PC_RESET_VALUE = 32'h8000_0000; // Fetch address after reset

    // ------------------------------
    // Instruction ROM geometry
    localparam int IMEM_WORDS = 256;                    // 32-bit words in the ROM
    localparam int IMEM_AW    = 8;                      // ROM word index width

    localparam IMEM_FILE = "imem_init.hex";             // Hex image for the ROM

    // ------------------------------
    // Fetch buffer and request limits
    localparam int BUF_HALVES      = 8;                 // Buffer depth in halfwords
    localparam int MAX_OUTSTANDING = 3;                 // Reads allowed in flight

    localparam int BUF_FILL_W = $clog2(BUF_HALVES + 1);      // Fill count width
    localparam int OUT_CNT_W  = $clog2(MAX_OUTSTANDING + 1); // Outstanding count width

    // ------------------------------
    // Memory response word
    // The bus moves whole words, the buffer unpacks them as two halfwords
    typedef union packed {
        logic [XL:0]      word;                         // Whole response word
        logic [1:0][15:0] half;                         // half[0] is the low halfword
    } frv_fetch_word_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frv_fetch \
    -f files.f \
    -o sim_fetch

# The ROM image is opened by name from the test folder
cd test
../obj_dir/sim_fetch > ../sim.log 2>&1
cd ..

cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

// ==== test/imem_init.hex ====
// One 32-bit word per line, low halfword holds the lower address
// Words 0 to 15 from the base, words 252 to 255 end the ROM window
00930001
45050050
00a00113
05058082
002081b3
82334581
02864020
fe010113
1141c606
00112623
07334781
8b8500f5
0000006f
45854501
00000013
00010001
@fc
05134505
80820010
02850001
00934581

// ==== test/tb_frv_fetch.sv ====
// Fetch front end testbench
// Walks a table of jump targets, collects instructions under random decode
// stalls and checks them against a model of the ROM image
`timescale 1ns/1ns
module tb_frv_fetch;
    import frv_pkg::*;

    // ------------------------------
    // Stimulus table
    localparam int ROWS = 9;
    localparam logic [XL:0] ROW_TARGET [ROWS] = '{
        PC_RESET_VALUE,                                 // Straight run from reset
        PC_RESET_VALUE + 32'h010,                       // Aligned jump mid-stream
        PC_RESET_VALUE + 32'h016,                       // Upper half with a 32-bit across words
        PC_RESET_VALUE + 32'h002,
        PC_RESET_VALUE + 32'h00e,                       // Upper half on a compressed one
        PC_RESET_VALUE + 32'h028,
        PC_RESET_VALUE + 32'h3f0,                       // Runs off the ROM end
        PC_RESET_VALUE + 32'h3fe,                       // Straddles the ROM end
        PC_RESET_VALUE                                  // Back into the image
    };
    localparam int ROW_COUNT [ROWS] = '{12, 10, 8, 10, 6, 6, 9, 3, 8};
    localparam bit ROW_JUMP  [ROWS] = '{0, 1, 1, 1, 1, 1, 1, 1, 1};
    localparam int unsigned SEED = 32'h34dc_a609;

    logic        g_clk;
    logic        g_resetn;
    logic        cf_req;
    logic [XL:0] cf_target;
    logic        cf_ack;
    logic        fe_flush;
    logic        fe_stall;
    logic        fe_ready;
    logic [XL:0] d_data;
    logic        d_error;

    logic [XL:0] img [IMEM_WORDS];                      // Copy of the ROM image
    logic [XL:0] exp_data [$];                          // Model output for one row
    logic        exp_err  [$];
    logic        hold_armed;                            // Stalled on a valid instruction
    logic [XL:0] held_data;
    int          data_errors;
    int          flag_errors;
    int          bus_errors;
    int          bus_outstanding;                       // Accepted reads not answered
    int          cycle_cnt;
    int          cycle_limit;

    frv_fetch_top uut (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_req    (cf_req),
        .cf_target (cf_target),
        .cf_ack    (cf_ack),
        .fe_flush  (fe_flush),
        .fe_stall  (fe_stall),
        .fe_ready  (fe_ready),
        .d_data    (d_data),
        .d_error   (d_error)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;                     // 100 ns period
    end

    // ------------------------------
    // Reference model of the image
    function automatic logic in_rom(input logic [XL:0] addr);
        logic [XL:0] off;
        off = addr - PC_RESET_VALUE;
        return off < 32'(IMEM_WORDS * 4);               // Below base wraps high
    endfunction

    function automatic logic [15:0] half_at(input logic [XL:0] addr);
        logic [XL:0] off;
        logic [XL:0] w;
        off = addr - PC_RESET_VALUE;
        if (!in_rom(addr)) begin
            return 16'h0000;                            // Error words read as zero
        end
        w = img[off[IMEM_AW+1:2]];
        return off[1] ? w[31:16] : w[15:0];
    endfunction

    task automatic build_expected(input logic [XL:0] target, input int count);
        logic [XL:0] pc;
        logic [15:0] lo;
        logic [15:0] hi;
        exp_data.delete();
        exp_err.delete();
        pc = target;
        for (int n = 0; n < count; n++) begin
            lo = half_at(pc);
            if (lo[1:0] == 2'b11) begin                 // Full-width instruction
                hi = half_at(pc + 2);
                exp_data.push_back({hi, lo});
                exp_err.push_back(!in_rom(pc) || !in_rom(pc + 2));
                pc = pc + 4;
            end else begin
                exp_data.push_back({16'h0000, lo});     // Compressed with zero upper half
                exp_err.push_back(!in_rom(pc));
                pc = pc + 2;
            end
        end
    endtask

    // ------------------------------
    // Compare tasks
    task automatic compare_word(input string name, input logic [XL:0] got,
                                input logic [XL:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("error: %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("error: %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ------------------------------
    // One clock step, with the read counter on the memory bus
    task automatic step();
        @(posedge g_clk);
        #5;                                             // Drive point after outputs settle
        if (cf_ack && bus_outstanding != 0) begin
            bus_errors++;
            $display("At %0t ns cf_ack was high while %0d reads were still outstanding",
                     $time, bus_outstanding);
        end
        bus_outstanding = bus_outstanding
                        + ((uut.imem_req && uut.imem_gnt) ? 1 : 0)
                        - (uut.imem_recv ? 1 : 0);
        if (bus_outstanding < 0) begin
            bus_errors++;
            $display("At %0t ns the ROM answered a read that was never accepted", $time);
            bus_outstanding = 0;
        end
    endtask

    task automatic change_flow(input logic [XL:0] target);
        step();
        cf_req    = 1'b1;
        cf_target = target;
        fe_flush  = 1'b1;
        fe_stall  = 1'b1;                               // Nothing to take while flushing
        while (!cf_ack) begin
            step();
        end
        step();                                         // Change taken at that edge
        cf_req   = 1'b0;
        fe_flush = 1'b0;
    endtask

    task automatic collect(input int count);
        int   idx;
        logic stall;
        idx        = 0;
        hold_armed = 1'b0;
        while (idx < count) begin
            step();
            if (hold_armed) begin                       // Stalled last cycle
                compare_bit("fe_ready held", fe_ready, 1'b1);
                compare_word("d_data held", d_data, held_data);
                hold_armed = 1'b0;
            end
            stall    = (($urandom % 100) < 30);
            fe_stall = stall;
            if (fe_ready && stall) begin
                hold_armed = 1'b1;
                held_data  = d_data;
            end else if (fe_ready) begin                // Consumed at next edge
                compare_word("d_data", d_data, exp_data[idx]);
                compare_bit("d_error", d_error, exp_err[idx]);
                idx++;
            end
        end
    endtask

    // ------------------------------
    // Watchdog
    initial begin
        cycle_limit = 200;
        for (int r = 0; r < ROWS; r++) begin
            cycle_limit = cycle_limit + 40 * ROW_COUNT[r];   // Per expected instruction
        end
        cycle_cnt = 0;
        while (cycle_cnt <= cycle_limit) begin
            @(posedge g_clk);
            cycle_cnt++;
        end
        $display("Run stopped after %0d cycles without finishing the table", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------
    // Main sequence
    initial begin
        g_resetn        = 1'b0;
        cf_req          = 1'b0;
        cf_target       = '0;
        fe_flush        = 1'b0;
        fe_stall        = 1'b0;
        hold_armed      = 1'b0;
        held_data       = '0;
        data_errors     = 0;
        flag_errors     = 0;
        bus_errors      = 0;
        bus_outstanding = 0;
        void'($urandom(SEED));
        $readmemh(IMEM_FILE, img);
        repeat (8) @(posedge g_clk);
        #5;
        g_resetn = 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            if (ROW_JUMP[r]) begin
                change_flow(ROW_TARGET[r]);
            end
            build_expected(ROW_TARGET[r], ROW_COUNT[r]);
            collect(ROW_COUNT[r]);
        end
        step();
        $display("Checks done with %0d data errors, %0d flag errors, %0d bus errors",
                 data_errors, flag_errors, bus_errors);
        if (data_errors + flag_errors + bus_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
